// File: common/afi_params.svh
// memory and AFI width macros for the DDR2 write path
// also stage count, beat FIFO depth, burst length and latency width
`ifndef AFI_PARAMS_SVH
`define AFI_PARAMS_SVH

// DQ pins on the memory side of one device
`define MEM_DQ_WIDTH 8

// one data mask pin covers the whole byte lane
`define MEM_DM_WIDTH 1

// number of write strobe groups
`define MEM_WRITE_DQS_WIDTH 1

// full rate carries both DDR edges in one AFI cycle
`define AFI_DATA_WIDTH (2 * `MEM_DQ_WIDTH)
`define AFI_DATA_MASK_WIDTH (2 * `MEM_DM_WIDTH)

// one strobe bit per group per half, the upper half is the later edge
`define AFI_DQS_WIDTH (2 * `MEM_WRITE_DQS_WIDTH)

// flop stages between the AFI and the DDIO cells for timing closure
`define NUM_WRITE_PATH_FLOP_STAGES 2

// beat buffer in the sequencer, holds two whole bursts
`define WR_FIFO_DEPTH 8

// BL8 at full rate is four AFI beats
`define BURST_BEATS 4

// write latency is counted in AFI cycles, 0 to 15
`define WLAT_WIDTH 4

`endif

// File: common/afi_pkg.sv
// AFI payload types shared by the write path RTL and its testbench
`default_nettype none

`include "afi_params.svh"

package afi_pkg;

	// one AFI write data word
	// the lower half goes out on the first DDR edge, the upper half on the second
	typedef logic [`AFI_DATA_WIDTH-1:0] afi_data_t;

	// one AFI byte mask
	// a set bit masks the matching byte, so that byte is not written in memory
	typedef logic [`AFI_DATA_MASK_WIDTH-1:0] afi_mask_t;

	// strobe vector with one bit per group and per half
	// the upper bits belong to the later half of the AFI cycle
	// used for dqs_en, wdata_valid, OCT enable and the force-off control
	typedef logic [`AFI_DQS_WIDTH-1:0] afi_strobe_t;

	// write latency in AFI cycles
	// calibration sets it, the sequencer samples it when a burst launches
	typedef logic [`WLAT_WIDTH-1:0] wlat_t;

endpackage

`default_nettype wire

// File: write_path/afi_delay_line.sv
// register chain of configurable length over any packed payload type
`timescale 1ns/1ps
`default_nettype none

module afi_delay_line #(
	parameter type payload_t = logic,
	parameter int STAGES = 1,
	parameter bit RESET_CLEAR = 1'b0
) (
	input wire logic pll_afi_clk,
	input wire logic rst,
	input wire payload_t d,
	output payload_t q
);

	generate
		if (STAGES == 0)
		begin : g_pass
			// no stages asked for, so the payload goes straight through
			assign q = d;
		end
		else
		begin : g_chain
			payload_t stage_q [STAGES];

			// stage 0 takes the input, every later stage takes the one before it
			// the reset term folds away when RESET_CLEAR is off
			always_ff @(posedge pll_afi_clk)
			begin
				if (RESET_CLEAR && rst)
				begin
					for (int i = 0; i < STAGES; i++)
						stage_q[i] <= '0;
				end
				else
				begin
					stage_q[0] <= d;
					for (int i = 1; i < STAGES; i++)
						stage_q[i] <= stage_q[i-1];
				end
			end

			// the last stage is the output
			assign q = stage_q[STAGES-1];
		end
	endgenerate

endmodule

`default_nettype wire

// File: write_path/write_datapath.sv
// AFI to DDIO write datapath with flop staging
// plus OCT enable generation and per-group force-off
`timescale 1ns/1ps
`default_nettype none

`include "afi_params.svh"

module write_datapath #(
	parameter int NUM_STAGES = `NUM_WRITE_PATH_FLOP_STAGES
) (
	input wire logic pll_afi_clk,
	input wire logic rst,
	input wire afi_pkg::afi_strobe_t force_oct_off,
	input wire afi_pkg::afi_strobe_t afi_dqs_en,
	input wire afi_pkg::afi_strobe_t afi_wdata_valid,
	input wire afi_pkg::afi_data_t afi_wdata,
	input wire afi_pkg::afi_mask_t afi_dm,
	output afi_pkg::afi_data_t phy_ddio_dq,
	output afi_pkg::afi_strobe_t phy_ddio_dqs_en,
	output afi_pkg::afi_strobe_t phy_ddio_wrdata_en,
	output afi_pkg::afi_strobe_t phy_ddio_oct_ena,
	output afi_pkg::afi_mask_t phy_ddio_wrdata_mask
);

	// width of one half of the strobe vector
	localparam int GROUPS = `MEM_WRITE_DQS_WIDTH;

	// upper half of the staged DQS enable, now and one AFI cycle ago
	logic [GROUPS-1:0] dqs_en_hi;
	logic [GROUPS-1:0] dqs_en_hi_q;
	afi_pkg::afi_strobe_t oct_ena;

	// data and mask chains carry payload only, no reset on these wide flops
	afi_delay_line #(
		.payload_t(afi_pkg::afi_data_t),
		.STAGES(NUM_STAGES),
		.RESET_CLEAR(1'b0)
	) u_dq_delay (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.d(afi_wdata),
		.q(phy_ddio_dq)
	);

	afi_delay_line #(
		.payload_t(afi_pkg::afi_mask_t),
		.STAGES(NUM_STAGES),
		.RESET_CLEAR(1'b0)
	) u_dm_delay (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.d(afi_dm),
		.q(phy_ddio_wrdata_mask)
	);

	// the strobe chains are control state and must come out of reset at zero
	// otherwise a stale DQS enable could drive the bus right after reset
	afi_delay_line #(
		.payload_t(afi_pkg::afi_strobe_t),
		.STAGES(NUM_STAGES),
		.RESET_CLEAR(1'b1)
	) u_dqs_en_delay (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.d(afi_dqs_en),
		.q(phy_ddio_dqs_en)
	);

	afi_delay_line #(
		.payload_t(afi_pkg::afi_strobe_t),
		.STAGES(NUM_STAGES),
		.RESET_CLEAR(1'b1)
	) u_wdata_valid_delay (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.d(afi_wdata_valid),
		.q(phy_ddio_wrdata_en)
	);

	assign dqs_en_hi = phy_ddio_dqs_en[`AFI_DQS_WIDTH-1:GROUPS];

	// the DDIO drives the upper half last, so its strobe still toggles
	// in the lower half of the next AFI cycle and termination stays off there
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
			dqs_en_hi_q <= '0;
		else
			dqs_en_hi_q <= dqs_en_hi;
	end

	// termination is on whenever this device does not drive DQS
	assign oct_ena = {~dqs_en_hi, ~(dqs_en_hi | dqs_en_hi_q)};

	// calibration can hold termination off per group and half
	assign phy_ddio_oct_ena = oct_ena & ~force_oct_off;

endmodule

`default_nettype wire

// File: write_path/write_sequencer.sv
// write sequencer with beat FIFO, burst count and write-latency FSM
// drives the AFI strobes, data and mask one beat per cycle
`timescale 1ns/1ps
`default_nettype none

`include "afi_params.svh"

module write_sequencer (
	input wire logic pll_afi_clk,
	input wire logic rst,
	input wire logic wr_valid,
	input wire afi_pkg::afi_data_t wr_data,
	input wire afi_pkg::afi_mask_t wr_mask,
	input wire afi_pkg::wlat_t wlat,
	output logic wr_ready,
	output afi_pkg::afi_data_t afi_wdata,
	output afi_pkg::afi_mask_t afi_dm,
	output afi_pkg::afi_strobe_t afi_dqs_en,
	output afi_pkg::afi_strobe_t afi_wdata_valid
);

	localparam int PTR_W = $clog2(`WR_FIFO_DEPTH);
	localparam int BEAT_W = $clog2(`BURST_BEATS);
	localparam int BURSTS_W = $clog2(`WR_FIFO_DEPTH / `BURST_BEATS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_PRE,
		ST_BEAT
	} state_t;

	afi_pkg::afi_data_t data_mem [`WR_FIFO_DEPTH];
	afi_pkg::afi_mask_t mask_mem [`WR_FIFO_DEPTH];

	// pointers carry one extra bit to tell full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic full;
	logic push;

	// beats accepted so far in the burst being filled
	logic [BEAT_W-1:0] accept_cnt;
	logic burst_done;

	// complete bursts in the FIFO that have not been launched yet
	logic [BURSTS_W-1:0] bursts_ready;
	logic launch;

	state_t state;
	afi_pkg::wlat_t wait_cnt;
	logic [BEAT_W-1:0] beat_cnt;
	logic last_beat;
	logic in_beat;
	logic in_strobe;

	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	// the PHY side never stalls, so only a full FIFO holds off the controller
	assign wr_ready = !full;
	assign push = wr_valid && wr_ready;

	assign burst_done = push && (accept_cnt == BEAT_W'(`BURST_BEATS - 1));
	assign last_beat = (beat_cnt == BEAT_W'(`BURST_BEATS - 1));
	assign in_beat = (state == ST_BEAT);
	assign in_strobe = (state == ST_PRE) || in_beat;

	// a burst leaves the ready count either from idle or straight after
	// the last beat of the previous one, which skips latency and preamble
	assign launch = (bursts_ready != '0) &&
		((state == ST_IDLE) || (in_beat && last_beat));

	// FIFO storage, payload only
	always_ff @(posedge pll_afi_clk)
	begin
		if (push)
		begin
			data_mem[wr_ptr[PTR_W-1:0]] <= wr_data;
			mask_mem[wr_ptr[PTR_W-1:0]] <= wr_mask;
		end
	end

	// pointer and burst bookkeeping
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			accept_cnt <= '0;
			bursts_ready <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
				accept_cnt <= accept_cnt + 1'b1;
			end
			// every beat cycle pops exactly one entry
			if (in_beat)
				rd_ptr <= rd_ptr + 1'b1;
			case ({burst_done, launch})
				2'b10: bursts_ready <= bursts_ready + 1'b1;
				2'b01: bursts_ready <= bursts_ready - 1'b1;
				default: bursts_ready <= bursts_ready;
			endcase
		end
	end

	// burst FSM: idle, latency wait, one preamble cycle, then the beats
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			wait_cnt <= '0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					// wlat is sampled only here, at the launch
					if (launch)
					begin
						wait_cnt <= wlat;
						if (wlat == '0)
							state <= ST_PRE;
						else
							state <= ST_WAIT;
					end
				end
				ST_WAIT:
				begin
					wait_cnt <= wait_cnt - 1'b1;
					if (wait_cnt == afi_pkg::wlat_t'(1))
						state <= ST_PRE;
				end
				ST_PRE:
				begin
					beat_cnt <= '0;
					state <= ST_BEAT;
				end
				default:
				begin
					if (last_beat)
					begin
						beat_cnt <= '0;
						// stay in the beat phase when the next burst is ready
						if (!launch)
							state <= ST_IDLE;
					end
					else
						beat_cnt <= beat_cnt + 1'b1;
				end
			endcase
		end
	end

	// strobes are registered from the state and copied to every group and half
	always_ff @(posedge pll_afi_clk)
	begin
		if (rst)
		begin
			afi_dqs_en <= '0;
			afi_wdata_valid <= '0;
		end
		else
		begin
			afi_dqs_en <= {`AFI_DQS_WIDTH{in_strobe}};
			afi_wdata_valid <= {`AFI_DQS_WIDTH{in_beat}};
		end
	end

	// data and mask load only on beats, so they hold between bursts
	always_ff @(posedge pll_afi_clk)
	begin
		if (in_beat)
		begin
			afi_wdata <= data_mem[rd_ptr[PTR_W-1:0]];
			afi_dm <= mask_mem[rd_ptr[PTR_W-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: source/afi_write_phy.sv
// top level of the DDR2 write PHY
// sequencer feeding the staged write datapath
`timescale 1ns/1ps
`default_nettype none

`include "afi_params.svh"

module afi_write_phy #(
	parameter int NUM_STAGES = `NUM_WRITE_PATH_FLOP_STAGES
) (
	input wire logic pll_afi_clk,
	input wire logic rst,
	input wire logic wr_valid,
	output logic wr_ready,
	input wire afi_pkg::afi_data_t wr_data,
	input wire afi_pkg::afi_mask_t wr_mask,
	input wire afi_pkg::wlat_t wlat,
	input wire afi_pkg::afi_strobe_t force_oct_off,
	output afi_pkg::afi_data_t phy_ddio_dq,
	output afi_pkg::afi_mask_t phy_ddio_wrdata_mask,
	output afi_pkg::afi_strobe_t phy_ddio_dqs_en,
	output afi_pkg::afi_strobe_t phy_ddio_wrdata_en,
	output afi_pkg::afi_strobe_t phy_ddio_oct_ena
);

	// AFI signals between the sequencer and the datapath
	afi_pkg::afi_data_t afi_wdata;
	afi_pkg::afi_mask_t afi_dm;
	afi_pkg::afi_strobe_t afi_dqs_en;
	afi_pkg::afi_strobe_t afi_wdata_valid;

	write_sequencer u_write_sequencer (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.wr_mask(wr_mask),
		.wlat(wlat),
		.wr_ready(wr_ready),
		.afi_wdata(afi_wdata),
		.afi_dm(afi_dm),
		.afi_dqs_en(afi_dqs_en),
		.afi_wdata_valid(afi_wdata_valid)
	);

	// force-off comes from calibration and bypasses the sequencer
	write_datapath #(
		.NUM_STAGES(NUM_STAGES)
	) u_write_datapath (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.force_oct_off(force_oct_off),
		.afi_dqs_en(afi_dqs_en),
		.afi_wdata_valid(afi_wdata_valid),
		.afi_wdata(afi_wdata),
		.afi_dm(afi_dm),
		.phy_ddio_dq(phy_ddio_dq),
		.phy_ddio_dqs_en(phy_ddio_dqs_en),
		.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
		.phy_ddio_oct_ena(phy_ddio_oct_ena),
		.phy_ddio_wrdata_mask(phy_ddio_wrdata_mask)
	);

endmodule

`default_nettype wire

// File: verif/afi_write_phy_assert.sv
// concurrent assertions on the DDIO strobes and OCT enable
// bound into every write_datapath instance
`timescale 1ns/1ps
`default_nettype none

`include "afi_params.svh"

module afi_write_phy_assert (
	input wire logic pll_afi_clk,
	input wire logic rst,
	input wire afi_pkg::afi_strobe_t phy_ddio_dqs_en,
	input wire afi_pkg::afi_strobe_t phy_ddio_wrdata_en,
	input wire afi_pkg::afi_strobe_t phy_ddio_oct_ena
);

	localparam int GROUPS = `MEM_WRITE_DQS_WIDTH;

	logic [GROUPS-1:0] dqs_en_hi;
	logic [GROUPS-1:0] oct_any;

	assign dqs_en_hi = phy_ddio_dqs_en[`AFI_DQS_WIDTH-1:GROUPS];
	// a group has termination on if either of its halves does
	assign oct_any = phy_ddio_oct_ena[`AFI_DQS_WIDTH-1:GROUPS] | phy_ddio_oct_ena[GROUPS-1:0];

	// data is only written while the strobe of the same half runs
	wrdata_needs_dqs: assert property (@(posedge pll_afi_clk) disable iff (rst)
		(phy_ddio_wrdata_en & ~phy_ddio_dqs_en) == '0)
		else $error("wrdata_en set without dqs_en");

	// termination must be off in both halves while the upper half drives DQS
	oct_off_while_driving: assert property (@(posedge pll_afi_clk) disable iff (rst)
		(oct_any & dqs_en_hi) == '0)
		else $error("OCT enabled while DQS is driven");

	// the strobe chains clear on the first reset edge
	strobes_clear_in_reset: assert property (@(posedge pll_afi_clk)
		$past(rst) |-> (phy_ddio_dqs_en == '0) && (phy_ddio_wrdata_en == '0))
		else $error("strobes not cleared by reset");

endmodule

bind write_datapath afi_write_phy_assert u_write_datapath_assert (
	.pll_afi_clk(pll_afi_clk),
	.rst(rst),
	.phy_ddio_dqs_en(phy_ddio_dqs_en),
	.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
	.phy_ddio_oct_ena(phy_ddio_oct_ena)
);

`default_nettype wire

// File: verif/afi_write_phy_tb.sv
// testbench for the AFI write PHY with LFSR stimulus and a beat queue
// also holds the OCT reference function, the compare process and a watchdog
`timescale 1ns/1ps
`default_nettype none

`include "afi_params.svh"

module afi_write_phy_tb;

	localparam int GROUPS = `MEM_WRITE_DQS_WIDTH;
	localparam int BEAT_BITS = `AFI_DATA_WIDTH + `AFI_DATA_MASK_WIDTH;
	localparam int BURSTS_PER_RUN = 6;
	// three latency runs in the first test and one run in each of the other four
	// plus two bursts that the last reset throws away
	localparam int TOTAL_BEATS = 7 * BURSTS_PER_RUN * `BURST_BEATS + 2 * `BURST_BEATS;
	localparam int MAX_WLAT = (1 << `WLAT_WIDTH) - 1;
	localparam int TIMEOUT_NS = TOTAL_BEATS * `WR_FIFO_DEPTH * (MAX_WLAT + 16) * 10;

	logic pll_afi_clk;
	logic rst;
	logic wr_valid;
	logic wr_ready;
	afi_pkg::afi_data_t wr_data;
	afi_pkg::afi_mask_t wr_mask;
	afi_pkg::wlat_t wlat;
	afi_pkg::afi_strobe_t force_oct_off;
	afi_pkg::afi_data_t phy_ddio_dq;
	afi_pkg::afi_mask_t phy_ddio_wrdata_mask;
	afi_pkg::afi_strobe_t phy_ddio_dqs_en;
	afi_pkg::afi_strobe_t phy_ddio_wrdata_en;
	afi_pkg::afi_strobe_t phy_ddio_oct_ena;

	// accepted beats as {mask, data} with the oldest first
	logic [BEAT_BITS-1:0] exp_q [$];
	logic [15:0] lfsr_state = 16'd71;
	string cur_test = "reset";
	int errors = 0;
	int test_num = 0;
	int tests_failed = 0;
	int start_errors = 0;
	int beats_in = 0;
	int beats_out = 0;
	int run_len = 0;
	bit saw_full = 0;
	// history of the DDIO strobes one and two cycles back
	logic [GROUPS-1:0] hi_prev = '0;
	logic dqs1 = 1'b0;
	logic dqs2 = 1'b0;
	logic wen1 = 1'b0;

	afi_write_phy uut (
		.pll_afi_clk(pll_afi_clk),
		.rst(rst),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.wr_data(wr_data),
		.wr_mask(wr_mask),
		.wlat(wlat),
		.force_oct_off(force_oct_off),
		.phy_ddio_dq(phy_ddio_dq),
		.phy_ddio_wrdata_mask(phy_ddio_wrdata_mask),
		.phy_ddio_dqs_en(phy_ddio_dqs_en),
		.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
		.phy_ddio_oct_ena(phy_ddio_oct_ena)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #5 pll_afi_clk = ~pll_afi_clk;
	end

	// Fibonacci LFSR over x^16 + x^14 + x^13 + x^11 + 1 that steps once per call
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// each bit taken costs one LFSR step
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// termination is off while the upper half drives DQS and through the following lower half
	function automatic afi_pkg::afi_strobe_t expected_oct(input logic [GROUPS-1:0] hi_now,
		input logic [GROUPS-1:0] hi_last, input afi_pkg::afi_strobe_t force_off);
		afi_pkg::afi_strobe_t oct;
		oct = {~hi_now, ~(hi_now | hi_last)};
		return oct & ~force_off;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (16) @(posedge pll_afi_clk);
		#1 rst = 1'b0;
	endtask

	// holds valid and data until wr_ready was high at a rising edge
	task automatic wait_accept();
		logic ok;
		do
		begin
			@(negedge pll_afi_clk);
			ok = wr_ready;
			@(posedge pll_afi_clk);
			#1;
		end
		while (!ok);
	endtask

	// sends whole bursts so that nothing is left stranded in the FIFO
	task automatic send_bursts(input int n, input bit gaps, input bit rand_force);
		for (int b = 0; b < n; b++)
		begin
			if (rand_force)
				force_oct_off = afi_pkg::afi_strobe_t'(rand_bits(`AFI_DQS_WIDTH));
			for (int k = 0; k < `BURST_BEATS; k++)
			begin
				wr_data = afi_pkg::afi_data_t'(rand_bits(`AFI_DATA_WIDTH));
				wr_mask = afi_pkg::afi_mask_t'(rand_bits(`AFI_DATA_MASK_WIDTH));
				wr_valid = 1'b1;
				wait_accept();
				if (gaps && rand_bits(1) != 0)
				begin
					wr_valid = 1'b0;
					@(posedge pll_afi_clk);
					#1;
				end
			end
		end
		wr_valid = 1'b0;
	endtask

	// waits for the queue to empty, then lets the trailing OCT half settle
	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge pll_afi_clk);
		repeat (6) @(posedge pll_afi_clk);
		#1;
		check_value("beat total", 32'(beats_in), 32'(beats_out));
	endtask

	task automatic begin_test(input string name);
		test_num++;
		cur_test = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		if (errors == start_errors)
			$display("test %0d %s: ok", test_num, cur_test);
		else
		begin
			$display("test %0d %s: %0d errors", test_num, cur_test, errors - start_errors);
			tests_failed++;
		end
	endtask

	// the compare process samples mid-cycle where every output has settled
	always @(negedge pll_afi_clk)
	begin : compare
		logic [GROUPS-1:0] hi_now;
		logic [BEAT_BITS-1:0] beat;
		hi_now = phy_ddio_dqs_en[`AFI_DQS_WIDTH-1:GROUPS];
		if (!rst)
		begin
			// wr_ready only changes after a rising edge, so this is the handshake
			if (wr_valid && wr_ready)
			begin
				exp_q.push_back({wr_mask, wr_data});
				beats_in++;
			end
			if (wr_valid && !wr_ready)
				saw_full = 1'b1;
			check_value("oct_ena", 32'(expected_oct(hi_now, hi_prev, force_oct_off)),
				32'(phy_ddio_oct_ena));
			if (&phy_ddio_wrdata_en)
			begin
				if (exp_q.size() == 0)
				begin
					$display("%s: a beat left the DDIO outputs that was never accepted", cur_test);
					errors++;
				end
				else
				begin
					beat = exp_q.pop_front();
					check_value("dq", 32'(beat[`AFI_DATA_WIDTH-1:0]), 32'(phy_ddio_dq));
					check_value("dm", 32'(beat[BEAT_BITS-1:`AFI_DATA_WIDTH]),
						32'(phy_ddio_wrdata_mask));
				end
				beats_out++;
				// a new run needs one preamble cycle with a quiet cycle before it
				if (!wen1)
				begin
					check_value("preamble dqs_en", 32'(1), 32'(dqs1));
					check_value("dqs_en before preamble", 32'(0), 32'(dqs2));
				end
				run_len++;
			end
			else if (run_len != 0)
			begin
				check_value("run length mod 4", 32'(0), 32'(run_len % `BURST_BEATS));
				run_len = 0;
			end
		end
		dqs2 = dqs1;
		dqs1 = &phy_ddio_dqs_en;
		wen1 = &phy_ddio_wrdata_en;
		hi_prev = hi_now;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog: run timed out in %s with %0d beats still queued",
			cur_test, exp_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		wr_valid = 1'b0;
		wr_data = '0;
		wr_mask = '0;
		wlat = '0;
		force_oct_off = '0;
		apply_reset();

		begin_test("data_integrity");
		wlat = afi_pkg::wlat_t'(0);
		send_bursts(BURSTS_PER_RUN, 1'b1, 1'b0);
		wait_drain();
		wlat = afi_pkg::wlat_t'(3);
		send_bursts(BURSTS_PER_RUN, 1'b1, 1'b0);
		wait_drain();
		wlat = afi_pkg::wlat_t'(MAX_WLAT);
		send_bursts(BURSTS_PER_RUN, 1'b1, 1'b0);
		wait_drain();
		end_test();

		// without gaps the later bursts are ready at the last beat and run back to back
		begin_test("burst_framing");
		wlat = afi_pkg::wlat_t'(2);
		send_bursts(BURSTS_PER_RUN, 1'b0, 1'b0);
		wait_drain();
		end_test();

		begin_test("oct_rule");
		wlat = afi_pkg::wlat_t'(1);
		send_bursts(BURSTS_PER_RUN, 1'b1, 1'b0);
		wait_drain();
		end_test();

		begin_test("force_off");
		send_bursts(BURSTS_PER_RUN, 1'b1, 1'b1);
		wait_drain();
		force_oct_off = '0;
		end_test();

		// a long latency keeps the first burst in the FIFO while the next ones arrive
		begin_test("back_pressure");
		saw_full = 1'b0;
		wlat = afi_pkg::wlat_t'(MAX_WLAT);
		send_bursts(BURSTS_PER_RUN, 1'b0, 1'b0);
		wait_drain();
		check_value("wr_ready dropped while full", 32'(1), 32'(saw_full));
		// two bursts fill the FIFO again while the first one waits out its latency
		send_bursts(2, 1'b0, 1'b0);
		wr_data = afi_pkg::afi_data_t'(rand_bits(`AFI_DATA_WIDTH));
		wr_mask = afi_pkg::afi_mask_t'(rand_bits(`AFI_DATA_MASK_WIDTH));
		wr_valid = 1'b1;
		@(negedge pll_afi_clk);
		check_value("wr_ready while full", 32'(0), 32'(wr_ready));
		@(posedge pll_afi_clk);
		#1;
		wr_valid = 1'b0;
		apply_reset();
		// the reset throws away both pending bursts
		exp_q.delete();
		@(negedge pll_afi_clk);
		check_value("wr_ready after reset", 32'(1), 32'(wr_ready));
		check_value("wrdata_en after reset", 32'(0), 32'(phy_ddio_wrdata_en));
		// a beat that still leaves the DDIO outputs now finds the queue empty
		repeat (MAX_WLAT + 8) @(posedge pll_afi_clk);
		#1;
		end_test();

		$display("tests: %0d run, %0d passed, %0d failed, %0d errors, %0d beats",
			test_num, test_num - tests_failed, tests_failed, errors, beats_out);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/afi_pkg.sv
write_path/afi_delay_line.sv
write_path/write_datapath.sv
write_path/write_sequencer.sv
source/afi_write_phy.sv
verif/afi_write_phy_assert.sv
verif/afi_write_phy_tb.sv

// File: Makefile
VERILATOR = verilator
TOP = afi_write_phy_tb
FILELIST = verilog.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS = --binary --timing --assert -Wno-fatal
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
